//--- hw/gw_clk_downsample.sv
`timescale 1ns/1ps

module gw_clk_downsample (
  input  logic bsg_bigblade_pcb,
  input  logic arst_n_i,
  input  logic done_i,
  output logic core_clk_en_o
);

  logic [$clog2(gw_tag_pkg::slowdown_ratio_lp)-1:0] cnt_r;
  logic                                             slow_tick;
  logic                                             en_r;

  // One tick at the end of every slowdown period
  assign slow_tick = (cnt_r == (gw_tag_pkg::slowdown_ratio_lp - 1));

  always_ff @(posedge bsg_bigblade_pcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_r <= '0;
    end else if (slow_tick) begin
      cnt_r <= '0;
    end else begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Enable strobe

  // Full rate from the cycle after programming is done
  always_ff @(posedge bsg_bigblade_pcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_r <= 1'b0;
    end else begin
      en_r <= done_i | slow_tick;
    end
  end

  assign core_clk_en_o = en_r;

endmodule

//--- hw/gw_tag_gateway.sv
`timescale 1ns/1ps

module gw_tag_gateway (
  input  logic                                        bsg_bigblade_pcb,
  input  logic                                        arst_n_i,
  input  logic                                        replay_en_i,
  output logic                                        tag_en_o,
  output logic                                        tag_data_o,
  output logic                                        output_disable_o,
  output logic [gw_tag_pkg::tag_payload_width_lp-1:0] cfg_o,
  output logic                                        core_clk_en_o,
  output logic                                        done_o
);

  logic [gw_tag_pkg::rom_addr_width_lp-1:0] rom_addr;
  gw_tag_pkg::tag_rom_word_s                rom_data;
  gw_tag_pkg::tag_bit_s                     tag_bit;
  logic                                     done;

  ////////////////////////////////////////////////////////////////////////////
  // Trace ROM feeding the replay stage

  gw_tag_trace_rom rom0 (
    .addr_i (rom_addr),
    .data_o (rom_data)
  );

  gw_tag_trace_replay replay0 (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .arst_n_i         (arst_n_i),
    .replay_en_i      (replay_en_i),
    .rom_addr_o       (rom_addr),
    .rom_data_i       (rom_data),
    .tag_bit_o        (tag_bit),
    .done_o           (done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Serial tag decode and core clock enable

  gw_tag_master master0 (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .arst_n_i         (arst_n_i),
    .tag_bit_i        (tag_bit),
    .output_disable_o (output_disable_o),
    .cfg_o            (cfg_o)
  );

  gw_clk_downsample ds0 (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .arst_n_i         (arst_n_i),
    .done_i           (done),
    .core_clk_en_o    (core_clk_en_o)
  );

  assign tag_en_o   = tag_bit.en;
  assign tag_data_o = tag_bit.data;
  assign done_o     = done;

endmodule

//--- hw/gw_tag_master.sv
`timescale 1ns/1ps

module gw_tag_master (
  input  logic                                        bsg_bigblade_pcb,
  input  logic                                        arst_n_i,
  input  gw_tag_pkg::tag_bit_s                        tag_bit_i,
  output logic                                        output_disable_o,
  output logic [gw_tag_pkg::tag_payload_width_lp-1:0] cfg_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_hdr,
    st_pay
  } state_e;

  state_e                                           state_r;
  logic [gw_tag_pkg::tag_len_width_lp-1:0]          cnt_r;
  logic [$clog2(gw_tag_pkg::tag_payload_width_lp)-1:0] idx_r;
  gw_tag_pkg::tag_hdr_s                             hdr_r;
  gw_tag_pkg::tag_hdr_s                             hdr_next;
  gw_tag_pkg::tag_hdr_s                             end_hdr;
  logic [gw_tag_pkg::tag_payload_width_lp-1:0]      pay_r;
  logic [gw_tag_pkg::tag_payload_width_lp-1:0]      pay_next;
  logic [gw_tag_pkg::tag_payload_width_lp-1:0]      end_pay;
  logic                                             hdr_last;
  logic                                             pay_last;
  logic                                             pkt_end;
  logic                                             disable_r;
  logic [gw_tag_pkg::tag_payload_width_lp-1:0]      cfg_r;

  // Header shifts in from the bottom; payload bits land MSB first
  always_comb begin
    hdr_next = {hdr_r[$bits(gw_tag_pkg::tag_hdr_s)-2:0], tag_bit_i.data};
    pay_next = pay_r;
    pay_next[idx_r] = tag_bit_i.data;
  end

  assign hdr_last = tag_bit_i.en && (state_r == st_hdr) && (cnt_r == 1'b1);
  assign pay_last = tag_bit_i.en && (state_r == st_pay) && (cnt_r == 1'b1);
  assign pkt_end  = (hdr_last && (hdr_next.len == '0)) || pay_last;

  // Last bit is folded in so the client updates right after it
  assign end_hdr = hdr_last ? hdr_next : hdr_r;
  assign end_pay = pay_last ? pay_next : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Deserializer FSM

  always_ff @(posedge bsg_bigblade_pcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= st_idle;
      cnt_r   <= '0;
      idx_r   <= '0;
    end else if (tag_bit_i.en) begin
      case (state_r)
        st_idle: begin
          if (tag_bit_i.data) begin
            state_r <= st_hdr;
            cnt_r   <= (gw_tag_pkg::tag_len_width_lp)'(gw_tag_pkg::tag_hdr_width_lp - 1);
          end
        end
        st_hdr: begin
          if (cnt_r != 1'b1) begin
            cnt_r <= cnt_r - 1'b1;
          end else if (hdr_next.len == '0) begin
            state_r <= st_idle;
          end else begin
            state_r <= st_pay;
            cnt_r   <= hdr_next.len;
            idx_r   <= '1;
          end
        end
        st_pay: begin
          if (cnt_r == 1'b1) begin
            state_r <= st_idle;
          end else begin
            cnt_r <= cnt_r - 1'b1;
            idx_r <= idx_r - 1'b1;
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge bsg_bigblade_pcb) begin
    if (tag_bit_i.en) begin
      if (state_r == st_idle) pay_r <= '0;
      if (state_r == st_hdr) hdr_r <= hdr_next;
      if (state_r == st_pay) pay_r <= pay_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Client registers, unknown node ids fall through

  always_ff @(posedge bsg_bigblade_pcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      disable_r <= gw_tag_pkg::disable_reset_lp;
      cfg_r     <= gw_tag_pkg::cfg_reset_lp;
    end else if (pkt_end) begin
      if (end_hdr.node_id == gw_tag_pkg::node_disable_lp) begin
        disable_r <= end_hdr.data_not_reset ?
                     end_pay[gw_tag_pkg::tag_payload_width_lp-1] : gw_tag_pkg::disable_reset_lp;
      end
      if (end_hdr.node_id == gw_tag_pkg::node_cfg_lp) begin
        cfg_r <= end_hdr.data_not_reset ? end_pay : gw_tag_pkg::cfg_reset_lp;
      end
    end
  end

  assign output_disable_o = disable_r;
  assign cfg_o            = cfg_r;

endmodule

//--- hw/gw_tag_pkg.sv
package gw_tag_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Field widths

  localparam int tag_id_width_lp      = 2;
  localparam int tag_len_width_lp     = 4;
  localparam int tag_payload_width_lp = 8;
  localparam int tag_op_width_lp      = 2;
  localparam int rom_addr_width_lp    = 4;
  localparam int tag_body_width_lp    = 15;

  // Start bit, node id, data_not_reset and length
  localparam int tag_hdr_width_lp    = 1 + tag_id_width_lp + 1 + tag_len_width_lp;
  localparam int tag_packet_width_lp = tag_hdr_width_lp + tag_payload_width_lp;

  // Core clock enable period while the trace is replayed
  localparam int slowdown_ratio_lp = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Client nodes and their reset values

  localparam logic [tag_id_width_lp-1:0]      node_disable_lp  = 2'd0;
  localparam logic [tag_id_width_lp-1:0]      node_cfg_lp      = 2'd1;
  localparam logic [tag_payload_width_lp-1:0] cfg_reset_lp     = 8'h00;
  localparam logic                            disable_reset_lp = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Trace ROM word

  typedef enum logic [tag_op_width_lp-1:0] {
    op_send_c   = 2'd0,
    op_wait_c   = 2'd1,
    op_finish_c = 2'd2
  } tag_op_e;

  // Field order matches the order bits go out on the wire
  typedef struct packed {
    logic [tag_id_width_lp-1:0]      node_id;
    logic                            data_not_reset;
    logic [tag_len_width_lp-1:0]     len;
    logic [tag_payload_width_lp-1:0] payload;
  } tag_send_s;

  typedef struct packed {
    logic [tag_body_width_lp-1:0] cycles;
  } tag_wait_s;

  // Same body bits, read as a packet or as a delay depending on the opcode
  typedef union packed {
    tag_send_s send;
    tag_wait_s delay;
  } tag_rom_body_u;

  typedef struct packed {
    tag_op_e       op;
    tag_rom_body_u body;
  } tag_rom_word_s;

  ////////////////////////////////////////////////////////////////////////////
  // Stage structs

  // Packet header as seen by the master, start bit already stripped
  typedef struct packed {
    logic [tag_id_width_lp-1:0]  node_id;
    logic                        data_not_reset;
    logic [tag_len_width_lp-1:0] len;
  } tag_hdr_s;

  typedef struct packed {
    logic en;
    logic data;
  } tag_bit_s;

endpackage

//--- hw/gw_tag_trace_replay.sv
`timescale 1ns/1ps

module gw_tag_trace_replay (
  input  logic                                     bsg_bigblade_pcb,
  input  logic                                     arst_n_i,
  input  logic                                     replay_en_i,
  output logic [gw_tag_pkg::rom_addr_width_lp-1:0] rom_addr_o,
  input  gw_tag_pkg::tag_rom_word_s                rom_data_i,
  output gw_tag_pkg::tag_bit_s                     tag_bit_o,
  output logic                                     done_o
);

  typedef enum logic [1:0] {
    st_fetch,
    st_shift,
    st_wait
  } state_e;

  state_e                                     state_r;
  logic [gw_tag_pkg::rom_addr_width_lp-1:0]   addr_r;
  logic [gw_tag_pkg::tag_body_width_lp-1:0]   cnt_r;
  logic [gw_tag_pkg::tag_packet_width_lp-1:0] sr_r;
  logic [gw_tag_pkg::tag_body_width_lp-1:0]   send_bits;
  logic                                       load_send;
  gw_tag_pkg::tag_bit_s                       tag_bit_r;
  logic                                       done_r;

  // Header plus the top len bits of the payload
  assign send_bits =
    (gw_tag_pkg::tag_body_width_lp)'(gw_tag_pkg::tag_hdr_width_lp) +
    (gw_tag_pkg::tag_body_width_lp)'(rom_data_i.body.send.len);

  assign load_send = (state_r == st_fetch) && (rom_data_i.op == gw_tag_pkg::op_send_c);

  ////////////////////////////////////////////////////////////////////////////
  // Trace walker

  always_ff @(posedge bsg_bigblade_pcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r   <= st_fetch;
      addr_r    <= '0;
      cnt_r     <= '0;
      tag_bit_r <= '0;
      done_r    <= 1'b0;
    end else begin
      // Bit strobe is quiet unless shifting
      tag_bit_r <= '0;
      if (replay_en_i) begin
        case (state_r)
          st_fetch: begin
            case (rom_data_i.op)
              gw_tag_pkg::op_send_c: begin
                cnt_r   <= send_bits;
                state_r <= st_shift;
              end
              gw_tag_pkg::op_wait_c: begin
                cnt_r   <= rom_data_i.body.delay.cycles;
                state_r <= st_wait;
              end
              // Finish entry, address stays parked on it
              default: done_r <= 1'b1;
            endcase
          end
          st_shift: begin
            tag_bit_r.en   <= 1'b1;
            tag_bit_r.data <= sr_r[gw_tag_pkg::tag_packet_width_lp-1];
            if (cnt_r == 1'b1) begin
              addr_r  <= addr_r + 1'b1;
              state_r <= st_fetch;
            end else begin
              cnt_r <= cnt_r - 1'b1;
            end
          end
          st_wait: begin
            // A zero count behaves like one
            if (cnt_r <= 1'b1) begin
              addr_r  <= addr_r + 1'b1;
              state_r <= st_fetch;
            end else begin
              cnt_r <= cnt_r - 1'b1;
            end
          end
          default: state_r <= st_fetch;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Packet shift register, MSB goes out first

  always_ff @(posedge bsg_bigblade_pcb) begin
    if (replay_en_i) begin
      if (load_send) begin
        sr_r <= {1'b1, rom_data_i.body.send};
      end else if (state_r == st_shift) begin
        sr_r <= {sr_r[gw_tag_pkg::tag_packet_width_lp-2:0], 1'b0};
      end
    end
  end

  assign rom_addr_o = addr_r;
  assign tag_bit_o  = tag_bit_r;
  assign done_o     = done_r;

endmodule

//--- hw/gw_tag_trace_rom.sv
`timescale 1ns/1ps

module gw_tag_trace_rom (
  input  logic [gw_tag_pkg::rom_addr_width_lp-1:0] addr_i,
  output gw_tag_pkg::tag_rom_word_s                data_o
);

  function automatic gw_tag_pkg::tag_rom_word_s send_word(
    input logic [gw_tag_pkg::tag_id_width_lp-1:0]      node_id,
    input logic                                        data_not_reset,
    input logic [gw_tag_pkg::tag_len_width_lp-1:0]     len,
    input logic [gw_tag_pkg::tag_payload_width_lp-1:0] payload
  );
    gw_tag_pkg::tag_rom_word_s word;
    word                          = '0;
    word.op                       = gw_tag_pkg::op_send_c;
    word.body.send.node_id        = node_id;
    word.body.send.data_not_reset = data_not_reset;
    word.body.send.len            = len;
    word.body.send.payload        = payload;
    return word;
  endfunction

  function automatic gw_tag_pkg::tag_rom_word_s wait_word(
    input logic [gw_tag_pkg::tag_body_width_lp-1:0] cycles
  );
    gw_tag_pkg::tag_rom_word_s word;
    word                   = '0;
    word.op                = gw_tag_pkg::op_wait_c;
    word.body.delay.cycles = cycles;
    return word;
  endfunction

  function automatic gw_tag_pkg::tag_rom_word_s finish_word();
    gw_tag_pkg::tag_rom_word_s word;
    word    = '0;
    word.op = gw_tag_pkg::op_finish_c;
    return word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Boot trace

  always_comb begin
    case (addr_i)
      // Let the clients settle before the first packet
      4'd0:    data_o = wait_word(15'd5);
      // Put both clients into their reset state
      4'd1:    data_o = send_word(gw_tag_pkg::node_disable_lp, 1'b0, 4'd0, 8'h00);
      4'd2:    data_o = send_word(gw_tag_pkg::node_cfg_lp, 1'b0, 4'd0, 8'h00);
      // Core configuration, then release the output disable
      4'd3:    data_o = send_word(gw_tag_pkg::node_cfg_lp, 1'b1, 4'd8, 8'h5A);
      4'd4:    data_o = send_word(gw_tag_pkg::node_disable_lp, 1'b1, 4'd1, 8'h00);
      4'd5:    data_o = wait_word(15'd3);
      default: data_o = finish_word();
    endcase
  end

endmodule

//--- sim/gw_tag_gateway_chk.sv
`timescale 1ns/1ps

module gw_tag_gateway_chk (
  input logic bsg_bigblade_pcb,
  input logic arst_n_i,
  input logic replay_en_i,
  input logic tag_en_i,
  input logic tag_data_i,
  input logic core_clk_en_i,
  input logic done_i
);

  int         fail_cnt = 0;
  logic [2:0] since_rst_r;
  logic [4:0] bit_idx_r;
  logic [3:0] len_r;
  logic [3:0] len_now;
  logic       pkt_last;
  logic       warm;

  ////////////////////////////////////////////////////////////////////////////
  // Packet framing on the serial tag

  // Length field is complete once bit 7 of the packet arrives
  assign len_now  = (bit_idx_r == 5'd7) ? {len_r[2:0], tag_data_i} : len_r;
  assign pkt_last = (bit_idx_r >= 5'd7) && (bit_idx_r == 5'd7 + 5'(len_now));
  // First full slow period after reset
  assign warm     = (since_rst_r >= 3'd4);

  always_ff @(posedge bsg_bigblade_pcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      since_rst_r <= '0;
      bit_idx_r   <= '0;
      len_r       <= '0;
    end else begin
      if (since_rst_r != 3'd7) since_rst_r <= since_rst_r + 1'b1;
      if (tag_en_i) begin
        if (bit_idx_r >= 5'd4 && bit_idx_r <= 5'd7) len_r <= {len_r[2:0], tag_data_i};
        bit_idx_r <= pkt_last ? 5'd0 : bit_idx_r + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Properties

  a_slow_rate: assert property (@(posedge bsg_bigblade_pcb) disable iff (!arst_n_i)
    warm && !$past(done_i) |-> $onehot({core_clk_en_i, $past(core_clk_en_i, 1),
                                        $past(core_clk_en_i, 2), $past(core_clk_en_i, 3)}))
  else begin
    fail_cnt = fail_cnt + 1;
    $error("core clock enable is not high in exactly one cycle of four");
  end

  a_full_rate: assert property (@(posedge bsg_bigblade_pcb) disable iff (!arst_n_i)
    $past(done_i) |-> core_clk_en_i)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("core clock enable dropped after done");
  end

  a_done_sticky: assert property (@(posedge bsg_bigblade_pcb) disable iff (!arst_n_i)
    $past(done_i) |-> done_i)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("done fell without a reset");
  end

  a_quiet_after_done: assert property (@(posedge bsg_bigblade_pcb) disable iff (!arst_n_i)
    done_i |-> !tag_en_i)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("tag bit sent after done");
  end

  // A bit needs an enabled edge to leave the replay stage
  a_quiet_paused: assert property (@(posedge bsg_bigblade_pcb) disable iff (!arst_n_i)
    !$past(replay_en_i) |-> !tag_en_i)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("tag bit sent while replay was paused");
  end

  a_start_bit: assert property (@(posedge bsg_bigblade_pcb) disable iff (!arst_n_i)
    tag_en_i && (bit_idx_r == 5'd0) |-> tag_data_i)
  else begin
    fail_cnt = fail_cnt + 1;
    $error("packet does not begin with a start bit of 1");
  end

endmodule

bind gw_tag_gateway gw_tag_gateway_chk chk0 (
  .bsg_bigblade_pcb (bsg_bigblade_pcb),
  .arst_n_i         (arst_n_i),
  .replay_en_i      (replay_en_i),
  .tag_en_i         (tag_en_o),
  .tag_data_i       (tag_data_o),
  .core_clk_en_i    (core_clk_en_o),
  .done_i           (done_o)
);

//--- sim/gw_tag_gateway_tb.sv
`timescale 1ns/1ps

module gw_tag_gateway_tb;

  logic        bsg_bigblade_pcb;
  logic        arst_n_i;
  logic        replay_en_i;
  logic        tag_en_o;
  logic        tag_data_o;
  logic        output_disable_o;
  logic [7:0]  cfg_o;
  logic        core_clk_en_o;
  logic        done_o;

  int          seed;
  int          tests_run;
  int          tests_failed;
  int          test_err;
  int          chk_base;
  string       test_name;
  int          run_cycles [2];
  int          run_paused [2];

  gw_tag_gateway dut0 (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .arst_n_i         (arst_n_i),
    .replay_en_i      (replay_en_i),
    .tag_en_o         (tag_en_o),
    .tag_data_o       (tag_data_o),
    .output_disable_o (output_disable_o),
    .cfg_o            (cfg_o),
    .core_clk_en_o    (core_clk_en_o),
    .done_o           (done_o)
  );

  initial begin
    bsg_bigblade_pcb = 1'b0;
    forever #20 bsg_bigblade_pcb = ~bsg_bigblade_pcb;
  end

  // Trace is 41 bits, 8 wait cycles and 7 fetches; two runs with reset and tail
  initial begin
    int limit;
    limit = 4 * (2 * (41 + 8 + 7 + 16 + 8) + 64);
    repeat (limit) @(posedge bsg_bigblade_pcb);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test bookkeeping

  task automatic start_test(input string name);
    test_name = name;
    test_err  = 0;
    chk_base  = dut0.chk0.fail_cnt;
  endtask

  task automatic finish_test();
    int chk_fails;
    chk_fails = dut0.chk0.fail_cnt - chk_base;
    tests_run++;
    if (test_err == 0 && chk_fails == 0) begin
      $display("test %-14s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d value errors and %0d assertion failures",
               test_name, test_err, chk_fails);
    end
  endtask

  task automatic compare_value(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      test_err++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic apply_reset();
    @(posedge bsg_bigblade_pcb);
    arst_n_i    <= 1'b0;
    replay_en_i <= 1'b1;
    repeat (15) @(posedge bsg_bigblade_pcb);
    @(negedge bsg_bigblade_pcb);
    compare_value("done_o", 0, done_o);
    compare_value("tag_en_o", 0, tag_en_o);
    compare_value("core_clk_en_o", 0, core_clk_en_o);
    compare_value("output_disable_o", 1, output_disable_o);
    compare_value("cfg_o", 8'h00, cfg_o);
    @(posedge bsg_bigblade_pcb);
    arst_n_i <= 1'b1;
  endtask

  // Replays the trace until done, optionally pausing at random
  task automatic run_trace(input int idx, input bit pause_en);
    int          cycles;
    int          tags;
    int          paused;
    int          pause_left;
    logic [31:0] rnd;
    cycles     = 0;
    tags       = 0;
    paused     = 0;
    pause_left = 64;
    while (!done_o && cycles < 4 * (56 + 64)) begin
      @(posedge bsg_bigblade_pcb);
      if (pause_en) begin
        rnd = $random(seed);
        replay_en_i <= rnd[0] || (pause_left == 0);
        if (!rnd[0] && pause_left > 0) pause_left--;
      end
      @(negedge bsg_bigblade_pcb);
      cycles++;
      if (tag_en_o) tags++;
      if (!done_o && !replay_en_i) paused++;
    end
    assert (done_o) else begin
      $display("Test %s: done_o did not rise within %0d cycles", test_name, cycles);
      test_err++;
    end
    compare_value("tag_en_o cycles", 41, tags);
    compare_value("cfg_o", 8'h5A, cfg_o);
    compare_value("output_disable_o", 0, output_disable_o);
    run_cycles[idx] = cycles;
    run_paused[idx] = paused;
    // Done must hold whatever the enable does
    repeat (8) begin
      @(posedge bsg_bigblade_pcb);
      if (pause_en) begin
        rnd = $random(seed);
        replay_en_i <= rnd[0];
      end
      @(negedge bsg_bigblade_pcb);
      compare_value("done_o held", 1, done_o);
    end
  endtask

  initial begin
    seed         = 32'ha5a3;
    tests_run    = 0;
    tests_failed = 0;
    arst_n_i     = 1'b0;
    replay_en_i  = 1'b1;

    start_test("reset_state");
    apply_reset();
    finish_test();
    start_test("trace_run");
    run_trace(0, 1'b0);
    // Unpaused trace takes 41 bit cycles, 8 wait cycles and 7 fetches
    compare_value("done latency", 41 + 8 + 7, run_cycles[0]);
    finish_test();
    start_test("reset_again");
    apply_reset();
    finish_test();
    start_test("paused_run");
    run_trace(1, 1'b1);
    finish_test();

    // Each paused edge delays done by one cycle
    start_test("pause_latency");
    assert (run_paused[1] > 0) else begin
      $display("Test %s: the random run never paused the replay", test_name);
      test_err++;
    end
    compare_value("done latency", 41 + 8 + 7 + run_paused[1], run_cycles[1]);
    finish_test();

    $display("%0d tests run, %0d failed, %0d assertion failures in total",
             tests_run, tests_failed, dut0.chk0.fail_cnt);
    if (tests_failed == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
hw/gw_tag_pkg.sv
hw/gw_tag_trace_rom.sv
hw/gw_tag_trace_replay.sv
hw/gw_tag_master.sv
hw/gw_clk_downsample.sv
hw/gw_tag_gateway.sv
sim/gw_tag_gateway_chk.sv
sim/gw_tag_gateway_tb.sv
